// File: compile.f
hdl/frame_fifo_pkg.sv
hdl/frame_buf_if.sv
hdl/frame_write_ctrl.sv
hdl/frame_store.sv
hdl/frame_out_stage.sv
hdl/axis_frame_fifo.sv
testbench/tb_axis_frame_fifo.sv

// File: hdl/axis_frame_fifo.sv
`default_nettype none

module axis_frame_fifo (
  input  logic                                  clk,
  input  logic                                  rst,

  // ingress, no ready
  input  logic                                  s_valid,
  input  logic [frame_fifo_pkg::data_width-1:0] s_data,
  input  logic                                  s_last,
  input  logic [frame_fifo_pkg::id_width-1:0]   s_id,
  input  logic [frame_fifo_pkg::dest_width-1:0] s_dest,
  input  logic                                  s_user,

  // egress
  output logic                                  m_valid,
  input  logic                                  m_ready,
  output logic [frame_fifo_pkg::data_width-1:0] m_data,
  output logic                                  m_last,
  output logic [frame_fifo_pkg::id_width-1:0]   m_id,
  output logic [frame_fifo_pkg::dest_width-1:0] m_dest,
  output logic                                  m_user,

  output logic                                  status_good,
  output logic                                  status_bad,
  output logic                                  status_overflow
);

  frame_fifo_pkg::flit_t rd_flit;
  frame_fifo_pkg::flit_t m_flit;
  logic                  pop;
  logic                  empty;

  frame_buf_if buf_if ();

  frame_write_ctrl frame_write_ctrl_i (
    .clk             (clk),
    .rst             (rst),
    .s_valid         (s_valid),
    .s_data          (s_data),
    .s_last          (s_last),
    .s_id            (s_id),
    .s_dest          (s_dest),
    .s_user          (s_user),
    .buf_if          (buf_if.ctrl),
    .status_good     (status_good),
    .status_bad      (status_bad),
    .status_overflow (status_overflow)
  );

  frame_store frame_store_i (
    .clk     (clk),
    .rst     (rst),
    .buf_if  (buf_if.store),
    .pop     (pop),
    .rd_flit (rd_flit),
    .empty   (empty)
  );

  frame_out_stage frame_out_stage_i (
    .clk     (clk),
    .rst     (rst),
    .rd_flit (rd_flit),
    .empty   (empty),
    .pop     (pop),
    .m_ready (m_ready),
    .m_valid (m_valid),
    .m_flit  (m_flit)
  );

  assign m_data = m_flit.data;
  assign m_last = m_flit.last;
  assign m_id   = m_flit.id;
  assign m_dest = m_flit.dest;
  assign m_user = m_flit.user;

endmodule

`default_nettype wire

// File: hdl/frame_buf_if.sv
`default_nettype none

interface frame_buf_if;

  // write side strobes, from the controller
  logic                  wr_en;     // store wr_flit and bump the current pointer
  frame_fifo_pkg::flit_t wr_flit;
  logic                  commit;    // publish the frame to the reader
  logic                  rollback;  // discard the frame being written

  // space flags, from the store
  logic full_cur;    // current pointer has reached the read pointer
  logic full_frame;  // frame in progress fills the whole buffer

  modport ctrl (
    output wr_en,
    output wr_flit,
    output commit,
    output rollback,
    input  full_cur,
    input  full_frame
  );

  modport store (
    input  wr_en,
    input  wr_flit,
    input  commit,
    input  rollback,
    output full_cur,
    output full_frame
  );

endinterface

`default_nettype wire

// File: hdl/frame_fifo_pkg.sv
`default_nettype none

package frame_fifo_pkg;

  // --------------------
  // sizes
  localparam int addr_width = 4;
  localparam int depth      = 16;  // 2**addr_width entries
  localparam int data_width = 8;
  localparam int id_width   = 4;
  localparam int dest_width = 4;

  localparam logic bad_user_value = 1'b1;  // user on last flit that marks a bad frame

  // --------------------
  // types
  typedef logic [addr_width:0] ptr_t;  // msb is the wrap bit

  typedef struct packed {
    logic [data_width-1:0] data;
    logic                  last;
    logic [id_width-1:0]   id;
    logic [dest_width-1:0] dest;
    logic                  user;
  } flit_t;

  typedef enum logic [1:0] {
    wr_idle,
    wr_pass,
    wr_drop
  } wr_state_e;

  // outcome of one frame, reported on the status pulses
  typedef enum logic [1:0] {
    res_good,
    res_bad,
    res_overflow
  } frame_result_e;

endpackage

`default_nettype wire

// File: hdl/frame_out_stage.sv
`default_nettype none

module frame_out_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  frame_fifo_pkg::flit_t rd_flit,
  input  logic                  empty,
  output logic                  pop,
  input  logic                  m_ready,
  output logic                  m_valid,
  output frame_fifo_pkg::flit_t m_flit
);

  logic mem_valid;   // rd_flit in the store holds a flit
  logic load_out;    // output register takes a new value
  logic slot_free;   // data slot can accept a pop

  assign load_out  = m_ready || !m_valid;
  assign slot_free = load_out || !mem_valid;
  assign pop       = slot_free && !empty;

  // --------------------
  // slot valid flags
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid <= 1'b0;
      m_valid   <= 1'b0;
    end else begin
      if (slot_free) begin
        mem_valid <= !empty;
      end
      if (load_out) begin
        m_valid <= mem_valid;
      end
    end
  end

  // output payload, held while stalled
  always_ff @(posedge clk) begin
    if (load_out) begin
      m_flit <= rd_flit;
    end
  end

endmodule

`default_nettype wire

// File: hdl/frame_store.sv
`default_nettype none

module frame_store (
  input  logic                  clk,
  input  logic                  rst,
  frame_buf_if.store            buf_if,
  input  logic                  pop,
  output frame_fifo_pkg::flit_t rd_flit,
  output logic                  empty
);

  frame_fifo_pkg::flit_t mem [frame_fifo_pkg::depth];

  frame_fifo_pkg::ptr_t wr_ptr;      // committed, visible to the reader
  frame_fifo_pkg::ptr_t wr_ptr_cur;  // head of the frame in progress
  frame_fifo_pkg::ptr_t rd_ptr;

  // --------------------
  // flags
  // full when addresses match but wrap bits differ
  assign buf_if.full_cur =
    (wr_ptr_cur[frame_fifo_pkg::addr_width] != rd_ptr[frame_fifo_pkg::addr_width]) &&
    (wr_ptr_cur[frame_fifo_pkg::addr_width-1:0] == rd_ptr[frame_fifo_pkg::addr_width-1:0]);

  assign buf_if.full_frame =
    (wr_ptr_cur[frame_fifo_pkg::addr_width] != wr_ptr[frame_fifo_pkg::addr_width]) &&
    (wr_ptr_cur[frame_fifo_pkg::addr_width-1:0] == wr_ptr[frame_fifo_pkg::addr_width-1:0]);

  // reader only sees committed frames
  assign empty = (wr_ptr == rd_ptr);

  // --------------------
  // pointers
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      wr_ptr_cur <= '0;
      rd_ptr     <= '0;
    end else begin
      if (buf_if.rollback) begin
        wr_ptr_cur <= wr_ptr;
      end else if (buf_if.wr_en) begin
        wr_ptr_cur <= wr_ptr_cur + 1'b1;
      end

      if (buf_if.commit) begin
        // include the last flit if it is written in this cycle
        wr_ptr <= wr_ptr_cur + frame_fifo_pkg::ptr_t'(buf_if.wr_en);
      end

      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // --------------------
  // memory
  always_ff @(posedge clk) begin
    if (buf_if.wr_en) begin
      mem[wr_ptr_cur[frame_fifo_pkg::addr_width-1:0]] <= buf_if.wr_flit;
    end
    if (pop) begin
      rd_flit <= mem[rd_ptr[frame_fifo_pkg::addr_width-1:0]];  // holds until next pop
    end
  end

endmodule

`default_nettype wire

// File: hdl/frame_write_ctrl.sv
`default_nettype none

module frame_write_ctrl (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  s_valid,
  input  logic [frame_fifo_pkg::data_width-1:0] s_data,
  input  logic                                  s_last,
  input  logic [frame_fifo_pkg::id_width-1:0]   s_id,
  input  logic [frame_fifo_pkg::dest_width-1:0] s_dest,
  input  logic                                  s_user,
  frame_buf_if.ctrl                             buf_if,
  output logic                                  status_good,
  output logic                                  status_bad,
  output logic                                  status_overflow
);

  frame_fifo_pkg::wr_state_e     state;
  frame_fifo_pkg::wr_state_e     state_next;
  frame_fifo_pkg::frame_result_e result;
  logic                          frame_done;  // last flit seen this cycle
  logic                          no_space;

  // incoming flit goes straight to the store
  always_comb begin
    buf_if.wr_flit.data = s_data;
    buf_if.wr_flit.last = s_last;
    buf_if.wr_flit.id   = s_id;
    buf_if.wr_flit.dest = s_dest;
    buf_if.wr_flit.user = s_user;
  end

  assign no_space = buf_if.full_cur || buf_if.full_frame;

  // --------------------
  // per flit decision
  always_comb begin
    buf_if.wr_en    = 1'b0;
    buf_if.commit   = 1'b0;
    buf_if.rollback = 1'b0;
    state_next      = state;
    frame_done      = 1'b0;
    result          = frame_fifo_pkg::res_good;

    if (s_valid) begin
      if (state == frame_fifo_pkg::wr_drop || no_space) begin
        // frame cannot be kept, swallow the rest of it
        state_next = frame_fifo_pkg::wr_drop;
        if (s_last) begin
          buf_if.rollback = 1'b1;
          frame_done      = 1'b1;
          result          = frame_fifo_pkg::res_overflow;
          state_next      = frame_fifo_pkg::wr_idle;
        end
      end else begin
        buf_if.wr_en = 1'b1;
        state_next   = frame_fifo_pkg::wr_pass;
        if (s_last) begin
          frame_done = 1'b1;
          state_next = frame_fifo_pkg::wr_idle;
          if (s_user == frame_fifo_pkg::bad_user_value) begin
            buf_if.wr_en    = 1'b0;  // no point writing it
            buf_if.rollback = 1'b1;
            result          = frame_fifo_pkg::res_bad;
          end else begin
            buf_if.commit = 1'b1;
          end
        end
      end
    end
  end

  // --------------------
  // state and status pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      state           <= frame_fifo_pkg::wr_idle;
      status_good     <= 1'b0;
      status_bad      <= 1'b0;
      status_overflow <= 1'b0;
    end else begin
      state           <= state_next;
      status_good     <= frame_done && (result == frame_fifo_pkg::res_good);
      status_bad      <= frame_done && (result == frame_fifo_pkg::res_bad);
      status_overflow <= frame_done && (result == frame_fifo_pkg::res_overflow);
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the frame FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_axis_frame_fifo -f compile.f

# exit status of the simulation is ignored here, the log decides
./obj_dir/Vtb_axis_frame_fifo > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi

if ! grep -q "TEST PASSED" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi

echo "simulation passed"

// File: testbench/tb_axis_frame_fifo.sv
`default_nettype none

module tb_axis_frame_fifo;
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum int {
    rdy_always,
    rdy_random,
    rdy_held
  } ready_mode_e;

  typedef struct packed {
    int                                  len;
    logic [frame_fifo_pkg::id_width-1:0]   id;
    logic [frame_fifo_pkg::dest_width-1:0] dest;
    bit                                  bad;
    ready_mode_e                         mode;
    bit                                  wait_drain;  // egress empty before sending
    int                                  gap;
  } frame_entry_t;

  logic                                  clk;
  logic                                  rst;
  logic                                  s_valid;
  logic [frame_fifo_pkg::data_width-1:0] s_data;
  logic                                  s_last;
  logic [frame_fifo_pkg::id_width-1:0]   s_id;
  logic [frame_fifo_pkg::dest_width-1:0] s_dest;
  logic                                  s_user;
  logic                                  m_valid;
  logic                                  m_ready;
  logic [frame_fifo_pkg::data_width-1:0] m_data;
  logic                                  m_last;
  logic [frame_fifo_pkg::id_width-1:0]   m_id;
  logic [frame_fifo_pkg::dest_width-1:0] m_dest;
  logic                                  m_user;
  logic                                  status_good;
  logic                                  status_bad;
  logic                                  status_overflow;

  frame_entry_t              frame_table[$];
  frame_fifo_pkg::flit_t     exp_q[$];     // flits of good frames not yet seen
  ready_mode_e               ready_mode;
  frame_fifo_pkg::wr_state_e dbg_state;
  int                        frame_idx;
  int                        flits_seen;

  axis_frame_fifo axis_frame_fifo_i (.*);

  assign dbg_state = axis_frame_fifo_i.frame_write_ctrl_i.state;

  always #10 clk = ~clk;

  // --------------------
  // reporting and compares
  task automatic end_with_failure();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string msg);
    $display("error at %0d ns: %s", $time, msg);
    end_with_failure();
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s, write state %s", what, dbg_state.name());
    end_with_failure();
  endtask

  task automatic check_flit(input frame_fifo_pkg::flit_t got, input frame_fifo_pkg::flit_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf(
        "egress flit %0d: data %h last %b id %h dest %h user %b, expected %h %b %h %h %b",
        flits_seen, got.data, got.last, got.id, got.dest, got.user,
        exp.data, exp.last, exp.id, exp.dest, exp.user));
    end
  endtask

  task automatic check_result(input frame_fifo_pkg::frame_result_e got,
                              input frame_fifo_pkg::frame_result_e exp);
    if (got != exp) begin
      report_mismatch($sformatf("frame %0d gave %s, expected %s",
                                frame_idx, got.name(), exp.name()));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
    end
  endtask

  // --------------------
  // one cycle, inputs change on the falling edge
  task automatic tick();
    logic [31:0] r;
    @(negedge clk);
    r = $urandom;
    case (ready_mode)
      rdy_always: m_ready = 1'b1;
      rdy_random: m_ready = r[0];
      default:    m_ready = 1'b0;
    endcase
  endtask

  task automatic check_quiet();
    check_bit("status_good", status_good, 1'b0);
    check_bit("status_bad", status_bad, 1'b0);
    check_bit("status_overflow", status_overflow, 1'b0);
  endtask

  task automatic idle_gap(input int n);
    repeat (n) begin
      tick();
      check_quiet();
    end
  endtask

  task automatic wait_drain(input string what);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0) begin
      if (cycles == 400) report_timeout(what);
      tick();
      cycles++;
    end
  endtask

  task automatic wait_status(input frame_fifo_pkg::frame_result_e exp_res);
    int                            cycles;
    frame_fifo_pkg::frame_result_e got;
    cycles = 0;
    while (!(status_good || status_bad || status_overflow)) begin
      if (cycles == 20) report_timeout("status pulse");
      tick();
      cycles++;
    end
    if ($countones({status_good, status_bad, status_overflow}) != 1) begin
      report_mismatch("more than one status output high");
    end
    if (status_good) got = frame_fifo_pkg::res_good;
    else if (status_bad) got = frame_fifo_pkg::res_bad;
    else got = frame_fifo_pkg::res_overflow;
    check_result(got, exp_res);
  endtask

  // expected result from the frame rules, then drive the flits
  task automatic send_frame(input frame_entry_t e,
                            output frame_fifo_pkg::frame_result_e exp_res);
    frame_fifo_pkg::flit_t f;
    logic [31:0]           r;
    if (e.len > frame_fifo_pkg::depth) begin
      exp_res = frame_fifo_pkg::res_overflow;
    end else if (e.mode == rdy_held && exp_q.size() + e.len > frame_fifo_pkg::depth + 2) begin
      exp_res = frame_fifo_pkg::res_overflow;  // buffer plus the two pipeline slots
    end else if (e.bad) begin
      exp_res = frame_fifo_pkg::res_bad;
    end else begin
      exp_res = frame_fifo_pkg::res_good;
    end

    for (int i = 0; i < e.len; i++) begin
      r      = $urandom;
      f.data = r[frame_fifo_pkg::data_width-1:0];
      f.last = (i == e.len - 1);
      f.id   = e.id;
      f.dest = e.dest;
      if (f.last) f.user = e.bad ? frame_fifo_pkg::bad_user_value : !frame_fifo_pkg::bad_user_value;
      else f.user = r[31];
      tick();
      s_valid = 1'b1;
      s_data  = f.data;
      s_last  = f.last;
      s_id    = f.id;
      s_dest  = f.dest;
      s_user  = f.user;
      if (exp_res == frame_fifo_pkg::res_good) exp_q.push_back(f);
    end
    tick();
    s_valid = 1'b0;
    s_last  = 1'b0;
  endtask

  task automatic add_entry(input int len,
                           input logic [frame_fifo_pkg::id_width-1:0] id,
                           input logic [frame_fifo_pkg::dest_width-1:0] dest,
                           input bit bad, input ready_mode_e mode, input bit wait_drain,
                           input int gap);
    frame_entry_t e;
    e = '{len, id, dest, bad, mode, wait_drain, gap};
    frame_table.push_back(e);
  endtask

  task automatic build_table();
    logic [31:0] r;
    add_entry(1, 4'h1, 4'h2, 0, rdy_always, 1, 4);
    add_entry(3, 4'h2, 4'h3, 0, rdy_always, 0, 4);
    add_entry(8, 4'h3, 4'h4, 0, rdy_always, 0, 4);
    add_entry(5, 4'h4, 4'h5, 1, rdy_always, 1, 4);   // bad, never at egress
    add_entry(4, 4'h5, 4'h6, 0, rdy_always, 0, 4);
    // egress stalled, third frame does not fit
    add_entry(8, 4'h6, 4'h7, 0, rdy_held, 1, 6);
    add_entry(8, 4'h7, 4'h8, 0, rdy_held, 0, 6);
    add_entry(4, 4'h8, 4'h9, 0, rdy_held, 0, 6);
    add_entry(3, 4'h9, 4'ha, 0, rdy_always, 1, 4);
    add_entry(20, 4'ha, 4'hb, 0, rdy_always, 1, 4);  // longer than the buffer
    add_entry(2, 4'hb, 4'hc, 0, rdy_always, 1, 4);
    repeat (30) begin
      r = $urandom;
      add_entry(1 + int'(r[3:0]) % 12, r[7:4], r[11:8], 0, rdy_random, 1,
                4 + int'(r[13:12]));
    end
  endtask

  // --------------------
  // egress monitor, sampled on the edge where the transfer happens
  always @(posedge clk) begin
    frame_fifo_pkg::flit_t got;
    if (!rst && m_valid && m_ready) begin
      got.data = m_data;
      got.last = m_last;
      got.id   = m_id;
      got.dest = m_dest;
      got.user = m_user;
      if (exp_q.size() == 0) report_mismatch("flit at egress with none expected");
      else check_flit(got, exp_q.pop_front());
      flits_seen++;
    end
  end

  initial begin
    frame_fifo_pkg::frame_result_e exp_res;
    frame_entry_t                  e;
    clk        = 1'b0;
    rst        = 1'b1;
    s_valid    = 1'b0;
    s_data     = '0;
    s_last     = 1'b0;
    s_id       = '0;
    s_dest     = '0;
    s_user     = 1'b0;
    m_ready    = 1'b0;
    ready_mode = rdy_always;
    frame_idx  = 0;
    flits_seen = 0;
    void'($urandom(57883));
    build_table();

    repeat (16) tick();
    rst = 1'b0;

    // quiet after reset
    repeat (10) begin
      tick();
      check_bit("m_valid", m_valid, 1'b0);
      check_quiet();
    end

    for (frame_idx = 0; frame_idx < frame_table.size(); frame_idx++) begin
      e = frame_table[frame_idx];
      if (e.wait_drain) begin
        ready_mode = rdy_always;
        wait_drain("egress to drain");
      end
      ready_mode = e.mode;
      send_frame(e, exp_res);
      wait_status(exp_res);
      idle_gap(e.gap);
    end

    ready_mode = rdy_always;
    wait_drain("final flits");
    idle_gap(20);  // anything left over would show up at egress here

    $display("%0d frames sent, %0d flits checked", frame_table.size(), flits_seen);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire
